// ==== Makefile ====
# tool, flags, top module and file list
VERILATOR  ?= verilator
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
TOP        = gpio_peri_tb
FILELIST   = list.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = Something failed
PASS_MSG   = Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# build, run, then search the log for the verdict
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/gpio_peri_tb.sv ====
// GPIO peripheral testbench
`default_nettype none
`timescale 1ns/1ps

module gpio_peri_tb
    import gpio_bus_pkg::*, gpio_pin_pkg::*;
();

    localparam int          CLK_NS    = 4;
    localparam int          NUM_TESTS = 6;
    localparam logic [31:0] SEED      = 32'h9158_3870;

    logic              clk;
    logic              rst;
    logic              bus_vld;
    logic              bus_wen;
    logic [BUS_AW-1:0] bus_adr;
    logic [BUS_DW-1:0] bus_wdt;
    logic [BUS_DW-1:0] bus_rdt;
    logic              bus_err;
    logic [GPIO_W-1:0] gpio_i;
    logic [GPIO_W-1:0] gpio_o;
    logic [GPIO_W-1:0] gpio_e;
    logic              irq;

    int err_cnt;
    int chk_cnt;

    gpio_peri gpio_peri_inst (
        .clk     (clk),
        .rst     (rst),
        .bus_vld (bus_vld),
        .bus_wen (bus_wen),
        .bus_adr (bus_adr),
        .bus_wdt (bus_wdt),
        .bus_rdt (bus_rdt),
        .bus_err (bus_err),
        .gpio_i  (gpio_i),
        .gpio_o  (gpio_o),
        .gpio_e  (gpio_e),
        .irq     (irq)
    );

    always #(CLK_NS / 2) clk = ~clk;

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_word(input string name, input logic [BUS_DW-1:0] exp,
                              input logic [BUS_DW-1:0] act);
        chk_cnt++;
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_pins(input string name, input logic [GPIO_W-1:0] exp,
                              input logic [GPIO_W-1:0] act);
        chk_cnt++;
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        chk_cnt++;
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    //////////////////////////////
    // bus helpers
    //////////////////////////////

    // byte address of a register index
    function automatic logic [BUS_AW-1:0] reg_adr(input logic [REG_IW-1:0] idx);
        return {idx, {REG_LSB{1'b0}}};
    endfunction

    // pin word zero extended to the bus
    function automatic logic [BUS_DW-1:0] widen(input logic [GPIO_W-1:0] p);
        return BUS_DW'(p);
    endfunction

    function automatic logic [GPIO_W-1:0] rand_pins();
        logic [31:0] r;
        r = $urandom();
        return r[GPIO_W-1:0];
    endfunction

    // starts on a rising edge and returns on the edge that ends the transfer
    task automatic bus_write(input logic [BUS_AW-1:0] adr, input logic [BUS_DW-1:0] data,
                             output logic err);
        bus_vld <= 1'b1;
        bus_wen <= 1'b1;
        bus_adr <= adr;
        bus_wdt <= data;
        @(negedge clk);
        err = bus_err;
        @(posedge clk);
        bus_vld <= 1'b0;
        bus_wen <= 1'b0;
    endtask

    // response sampled mid cycle before the closing edge
    task automatic bus_read(input logic [BUS_AW-1:0] adr, output logic [BUS_DW-1:0] data,
                            output logic err);
        bus_vld <= 1'b1;
        bus_wen <= 1'b0;
        bus_adr <= adr;
        @(negedge clk);
        data = bus_rdt;
        err  = bus_err;
        @(posedge clk);
        bus_vld <= 1'b0;
    endtask

    // good write with no error expected
    task automatic write_reg(input logic [REG_IW-1:0] idx, input logic [BUS_DW-1:0] data);
        logic err;
        bus_write(reg_adr(idx), data, err);
        check_bit("bus_err", 1'b0, err);
    endtask

    task automatic read_reg(input logic [REG_IW-1:0] idx, input logic [BUS_DW-1:0] exp);
        logic [BUS_DW-1:0] data;
        logic              err;
        bus_read(reg_adr(idx), data, err);
        check_word("bus_rdt", exp, data);
        check_bit("bus_err", 1'b0, err);
    endtask

    task automatic check_outputs(input logic [GPIO_W-1:0] exp_o, input logic [GPIO_W-1:0] exp_e);
        @(negedge clk);
        check_pins("gpio_o", exp_o, gpio_o);
        check_pins("gpio_e", exp_e, gpio_e);
        @(posedge clk);
    endtask

    // poll irq once per cycle until it reaches level
    task automatic wait_irq(input logic level, input int max_cycles);
        int n;
        n = 0;
        @(negedge clk);
        while (irq !== level && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        chk_cnt++;
        if (irq !== level) begin
            $display("irq did not go to %0d within %0d cycles", level, max_cycles);
            err_cnt++;
        end
        @(posedge clk);
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    // register model kept by the tests
    logic [GPIO_W-1:0] m_out;
    logic [GPIO_W-1:0] m_oen;
    logic [GPIO_W-1:0] m_ien;
    logic [GPIO_W-1:0] pins;

    task automatic test_reset();
        check_outputs('0, '0);
        @(negedge clk);
        check_bit("irq", 1'b0, irq);
        @(posedge clk);
        for (int i = 0; i < 7; i++) begin
            read_reg(REG_IW'(i), '0);
        end
    endtask

    task automatic test_regs();
        logic [BUS_DW-1:0] w_out;
        logic [BUS_DW-1:0] w_oen;
        w_out = $urandom();
        w_oen = $urandom();
        write_reg(REG_OUT, w_out);
        write_reg(REG_OEN, w_oen);
        m_out = w_out[GPIO_W-1:0];
        m_oen = w_oen[GPIO_W-1:0];
        check_outputs(m_out, m_oen);
        read_reg(REG_OUT, widen(m_out));
        read_reg(REG_OEN, widen(m_oen));
        // read only and silently dropped
        write_reg(REG_IN, $urandom());
        read_reg(REG_OUT, widen(m_out));
        read_reg(REG_OEN, widen(m_oen));
        read_reg(REG_IN, '0);
    endtask

    task automatic test_input();
        m_ien = '1;
        write_reg(REG_IEN, widen(m_ien));
        pins = rand_pins();
        gpio_i <= pins;
        repeat (SYNC_N + 1) @(posedge clk);
        read_reg(REG_IN, widen(pins));
        // gate closed so the value is masked off at once
        m_ien = '0;
        write_reg(REG_IEN, '0);
        read_reg(REG_IN, '0);
    endtask

    task automatic test_edges();
        logic [GPIO_W-1:0] rmask;
        logic [GPIO_W-1:0] fmask;
        logic [GPIO_W-1:0] nxt;
        logic [GPIO_W-1:0] exp_sts;
        m_ien = '1;
        write_reg(REG_IEN, widen(m_ien));
        pins = rand_pins();
        gpio_i <= pins;
        // let the pipeline settle before any edge is enabled
        repeat (SYNC_N + 2) @(posedge clk);
        // pin 0 toggles and counts for both edges so status is never empty
        rmask = rand_pins() | GPIO_W'(1);
        fmask = rand_pins() | GPIO_W'(1);
        write_reg(REG_RISE, widen(rmask));
        write_reg(REG_FALL, widen(fmask));
        nxt = pins ^ (rand_pins() | GPIO_W'(1));
        exp_sts = (nxt & ~pins & rmask) | (~nxt & pins & fmask);
        pins = nxt;
        gpio_i <= pins;
        wait_irq(1'b1, 20);
        read_reg(REG_STS, widen(exp_sts));
        write_reg(REG_STS, widen('1));
        read_reg(REG_STS, '0);
        wait_irq(1'b0, 2);
    endtask

    task automatic test_partial_clear();
        write_reg(REG_RISE, widen('1));
        write_reg(REG_FALL, widen('1));
        // every pin flips and sets its bit
        pins = ~pins;
        gpio_i <= pins;
        wait_irq(1'b1, 20);
        read_reg(REG_STS, widen('1));
        write_reg(REG_STS, BUS_DW'(1));
        read_reg(REG_STS, widen(~GPIO_W'(1)));
        repeat (3) begin
            @(negedge clk);
            check_bit("irq", 1'b1, irq);
            @(posedge clk);
        end
        // clean up for the next test
        write_reg(REG_STS, widen('1));
        wait_irq(1'b0, 2);
        write_reg(REG_RISE, '0);
        write_reg(REG_FALL, '0);
    endtask

    task automatic test_bus_err();
        logic [BUS_DW-1:0] data;
        logic              err;
        bus_read(reg_adr(3'd7), data, err);
        check_bit("bus_err", 1'b1, err);
        bus_write(reg_adr(3'd7), $urandom(), err);
        check_bit("bus_err", 1'b1, err);
        bus_write(reg_adr(REG_OUT) + BUS_AW'(1), $urandom(), err);
        check_bit("bus_err", 1'b1, err);
        bus_write(reg_adr(REG_OEN) + BUS_AW'(2), $urandom(), err);
        check_bit("bus_err", 1'b1, err);
        bus_write(reg_adr(REG_IEN) + BUS_AW'(3), '0, err);
        check_bit("bus_err", 1'b1, err);
        bus_write(reg_adr(REG_RISE) + BUS_AW'(2), $urandom(), err);
        check_bit("bus_err", 1'b1, err);
        bus_read(reg_adr(REG_RISE) + BUS_AW'(1), data, err);
        check_bit("bus_err", 1'b1, err);
        // nothing moved
        read_reg(REG_OUT, widen(m_out));
        read_reg(REG_OEN, widen(m_oen));
        read_reg(REG_IEN, widen(m_ien));
        read_reg(REG_RISE, '0);
        read_reg(REG_FALL, '0);
        check_outputs(m_out, m_oen);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        void'($urandom(SEED));
        err_cnt  = 0;
        chk_cnt  = 0;
        clk      = 1'b0;
        rst      = 1'b1;
        bus_vld  = 1'b0;
        bus_wen  = 1'b0;
        bus_adr  = '0;
        bus_wdt  = '0;
        gpio_i   = '0;
        m_out    = '0;
        m_oen    = '0;
        m_ien    = '0;
        pins     = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        test_reset();
        test_regs();
        test_input();
        test_edges();
        test_partial_clear();
        test_bus_err();

        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // hard stop if a test hangs
    initial begin
        #(NUM_TESTS * 200 * CLK_NS);
        $display("timeout: the tests did not finish in time");
        $display("Something failed");
        $finish;
    end

endmodule : gpio_peri_tb

`default_nettype wire

// ==== list.f ====
src/gpio_bus_pkg.sv
src/gpio_pin_pkg.sv
src/gpio_input_sync.sv
src/gpio_edge_detect.sv
src/gpio_regs.sv
src/gpio_peri.sv
bench/gpio_peri_tb.sv

// ==== src/gpio_bus_pkg.sv ====
// GPIO bus register map
`default_nettype none

package gpio_bus_pkg;

    // bus data width
    localparam int unsigned BUS_DW = 32;
    // byte address width, covers 8 word registers
    localparam int unsigned BUS_AW = 5;

    // register index width
    localparam int unsigned REG_IW = 3;
    // index sits above the byte offset, address bits 4 to 2
    localparam int unsigned REG_LSB = 2;

    // register indices
    localparam logic [REG_IW-1:0] REG_OUT  = 3'd0;  // output value
    localparam logic [REG_IW-1:0] REG_OEN  = 3'd1;  // drive enable
    localparam logic [REG_IW-1:0] REG_IN   = 3'd2;  // synchronized input, read only
    localparam logic [REG_IW-1:0] REG_IEN  = 3'd3;  // input enable
    localparam logic [REG_IW-1:0] REG_RISE = 3'd4;  // rising edge irq enable
    localparam logic [REG_IW-1:0] REG_FALL = 3'd5;  // falling edge irq enable
    localparam logic [REG_IW-1:0] REG_STS  = 3'd6;  // sticky status, write 1 to clear

    // highest mapped index
    // index 7 answers with an error
    localparam logic [REG_IW-1:0] REG_LAST = 3'd6;

endpackage : gpio_bus_pkg

`default_nettype wire

// ==== src/gpio_edge_detect.sv ====
// GPIO input gate and edge detector
`default_nettype none
`timescale 1ns/1ps

module gpio_edge_detect
    import gpio_pin_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    // synchronized pins
    input  logic [GPIO_W-1:0] pin_sync,
    // per pin input enable
    input  logic [GPIO_W-1:0] in_en,
    // gated value
    output logic [GPIO_W-1:0] pin_val,
    // single cycle edge pulses
    output logic [GPIO_W-1:0] pin_rise,
    output logic [GPIO_W-1:0] pin_fall
);

    // gated input, current cycle
    logic [GPIO_W-1:0] gated;
    // gated input, previous cycle
    logic [GPIO_W-1:0] prev_q;

    // disabled pins read as low
    assign gated = pin_sync & in_en;

    // history register
    // zero after reset so a pin held high stays quiet until enabled
    always_ff @(posedge clk) begin
        if (rst) begin
            prev_q <= '0;
        end else begin
            prev_q <= gated;
        end
    end

    // value follows the gate without delay
    assign pin_val = gated;

    // rise when low last cycle and high now
    assign pin_rise = gated & ~prev_q;

    // fall is the mirror image
    // clearing in_en on a high pin shows up here as a fall
    assign pin_fall = ~gated & prev_q;

endmodule : gpio_edge_detect

`default_nettype wire

// ==== src/gpio_input_sync.sv ====
// GPIO input synchronizer
`default_nettype none
`timescale 1ns/1ps

module gpio_input_sync
    import gpio_pin_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    // asynchronous pin values
    input  logic [GPIO_W-1:0] pin_raw,
    // values in the clk domain
    output logic [GPIO_W-1:0] pin_sync
);

    generate
        if (SYNC_N == 0) begin : g_bypass
            // inputs already synchronous
            assign pin_sync = pin_raw;
        end else begin : g_chain
            // flop chain, stage 0 samples the raw pins
            logic [GPIO_W-1:0] stage_q [SYNC_N];

            always_ff @(posedge clk) begin
                if (rst) begin
                    for (int i = 0; i < SYNC_N; i++) begin
                        stage_q[i] <= '0;
                    end
                end else begin
                    stage_q[0] <= pin_raw;
                    // shift toward the last stage
                    for (int i = 1; i < SYNC_N; i++) begin
                        stage_q[i] <= stage_q[i-1];
                    end
                end
            end

            // last stage is the settled value
            assign pin_sync = stage_q[SYNC_N-1];
        end
    endgenerate

endmodule : gpio_input_sync

`default_nettype wire

// ==== src/gpio_peri.sv ====
// GPIO peripheral top
`default_nettype none
`timescale 1ns/1ps

module gpio_peri
    import gpio_bus_pkg::*, gpio_pin_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    // system bus, no wait states
    input  logic              bus_vld,
    input  logic              bus_wen,
    input  logic [BUS_AW-1:0] bus_adr,
    input  logic [BUS_DW-1:0] bus_wdt,
    output logic [BUS_DW-1:0] bus_rdt,
    output logic              bus_err,
    // pins
    input  logic [GPIO_W-1:0] gpio_i,
    output logic [GPIO_W-1:0] gpio_o,
    output logic [GPIO_W-1:0] gpio_e,
    // interrupt
    output logic              irq
);

    //////////////////////////////
    // input pipeline
    //////////////////////////////

    // between synchronizer and edge detector
    logic [GPIO_W-1:0] pin_sync;
    // between edge detector and registers
    logic [GPIO_W-1:0] pin_val;
    logic [GPIO_W-1:0] pin_rise;
    logic [GPIO_W-1:0] pin_fall;
    // enable mask fed back from the registers
    logic [GPIO_W-1:0] in_en;

    // cdc stage
    gpio_input_sync gpio_input_sync_inst (
        .clk      (clk),
        .rst      (rst),
        .pin_raw  (gpio_i),
        .pin_sync (pin_sync)
    );

    // gate and edges
    gpio_edge_detect gpio_edge_detect_inst (
        .clk      (clk),
        .rst      (rst),
        .pin_sync (pin_sync),
        .in_en    (in_en),
        .pin_val  (pin_val),
        .pin_rise (pin_rise),
        .pin_fall (pin_fall)
    );

    //////////////////////////////
    // register stage
    //////////////////////////////

    gpio_regs gpio_regs_inst (
        .clk      (clk),
        .rst      (rst),
        .bus_vld  (bus_vld),
        .bus_wen  (bus_wen),
        .bus_adr  (bus_adr),
        .bus_wdt  (bus_wdt),
        .bus_rdt  (bus_rdt),
        .bus_err  (bus_err),
        .pin_val  (pin_val),
        .pin_rise (pin_rise),
        .pin_fall (pin_fall),
        .in_en    (in_en),
        .gpio_o   (gpio_o),
        .gpio_e   (gpio_e),
        .irq      (irq)
    );

endmodule : gpio_peri

`default_nettype wire

// ==== src/gpio_pin_pkg.sv ====
// GPIO pin configuration
`default_nettype none

package gpio_pin_pkg;

    // number of pins
    // keep at or below the bus data width
    localparam int unsigned GPIO_W = 16;

    // synchronizer flop count
    // 0 bypasses the CDC stage entirely
    localparam int unsigned SYNC_N = 2;

endpackage : gpio_pin_pkg

`default_nettype wire

// ==== src/gpio_regs.sv ====
// GPIO register stage
`default_nettype none
`timescale 1ns/1ps

module gpio_regs
    import gpio_bus_pkg::*, gpio_pin_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    // bus request
    input  logic              bus_vld,
    input  logic              bus_wen,
    input  logic [BUS_AW-1:0] bus_adr,
    input  logic [BUS_DW-1:0] bus_wdt,
    // bus response, same cycle
    output logic [BUS_DW-1:0] bus_rdt,
    output logic              bus_err,
    // from the edge detector
    input  logic [GPIO_W-1:0] pin_val,
    input  logic [GPIO_W-1:0] pin_rise,
    input  logic [GPIO_W-1:0] pin_fall,
    // back to the edge detector
    output logic [GPIO_W-1:0] in_en,
    // pin drivers
    output logic [GPIO_W-1:0] gpio_o,
    output logic [GPIO_W-1:0] gpio_e,
    // interrupt request
    output logic              irq
);

    //////////////////////////////
    // address decode
    //////////////////////////////

    logic [REG_IW-1:0] reg_idx;
    logic              adr_ok;
    logic              wr_en;
    logic              rd_en;

    // word index from the byte address
    assign reg_idx = bus_adr[REG_LSB +: REG_IW];

    // word aligned and inside the map
    assign adr_ok = (bus_adr[REG_LSB-1:0] == '0) && (reg_idx <= REG_LAST);

    // only good addresses touch the registers
    assign wr_en = bus_vld &  bus_wen & adr_ok;
    assign rd_en = bus_vld & ~bus_wen & adr_ok;

    // error flagged for any bad transfer, read or write
    assign bus_err = bus_vld & ~adr_ok;

    //////////////////////////////
    // control registers
    //////////////////////////////

    logic [GPIO_W-1:0] wdt;
    logic [GPIO_W-1:0] out_q;
    logic [GPIO_W-1:0] oen_q;
    logic [GPIO_W-1:0] ien_q;
    logic [GPIO_W-1:0] rise_q;
    logic [GPIO_W-1:0] fall_q;

    // upper data bits have no pins behind them
    assign wdt = bus_wdt[GPIO_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            out_q  <= '0;
            oen_q  <= '0;
            ien_q  <= '0;
            rise_q <= '0;
            fall_q <= '0;
        end else if (wr_en) begin
            // REG_IN and REG_STS handled elsewhere or ignored
            case (reg_idx)
                REG_OUT:  out_q  <= wdt;
                REG_OEN:  oen_q  <= wdt;
                REG_IEN:  ien_q  <= wdt;
                REG_RISE: rise_q <= wdt;
                REG_FALL: fall_q <= wdt;
                default:  ;
            endcase
        end
    end

    assign gpio_o = out_q;
    assign gpio_e = oen_q;
    assign in_en  = ien_q;

    //////////////////////////////
    // status and interrupt
    //////////////////////////////

    logic [GPIO_W-1:0] evt;
    logic [GPIO_W-1:0] clr;
    logic [GPIO_W-1:0] sts_q;
    logic              irq_q;

    // edges that software asked for
    assign evt = (pin_rise & rise_q) | (pin_fall & fall_q);

    // write one to clear
    assign clr = (wr_en && (reg_idx == REG_STS)) ? wdt : '0;

    // new events win over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            sts_q <= '0;
        end else begin
            sts_q <= (sts_q & ~clr) | evt;
        end
    end

    // one cycle behind status
    always_ff @(posedge clk) begin
        if (rst) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= |sts_q;
        end
    end

    assign irq = irq_q;

    //////////////////////////////
    // read multiplexer
    //////////////////////////////

    logic [GPIO_W-1:0] rd_pin;

    always_comb begin
        case (reg_idx)
            REG_OUT:  rd_pin = out_q;
            REG_OEN:  rd_pin = oen_q;
            REG_IN:   rd_pin = pin_val;
            REG_IEN:  rd_pin = ien_q;
            REG_RISE: rd_pin = rise_q;
            REG_FALL: rd_pin = fall_q;
            REG_STS:  rd_pin = sts_q;
            default:  rd_pin = '0;
        endcase
    end

    // zero extend, quiet when not reading
    always_comb begin
        bus_rdt = '0;
        if (rd_en) begin
            bus_rdt[GPIO_W-1:0] = rd_pin;
        end
    end

endmodule : gpio_regs

`default_nettype wire
